// File: hw/cpuPkg.sv
`default_nettype none

package cpuPkg;

	localparam int WordWidth    = 32;
	localparam int RegAddrWidth = 5;
	localparam int NumRegs      = 32;
	localparam int PcWidth      = 6;
	localparam int ProgDepth    = 64;
	localparam int ImmWidth     = 15;
	localparam int OpcodeWidth  = 6;
	localparam int NibbleWidth  = 4;
	localparam int NumDigits    = 4;
	localparam int SegWidth     = 7;
	localparam int LuiShift     = 17; // load-upper places the constant at bit 17

	// instruction fields
	localparam int OpcodeMsb = 31;
	localparam int OpcodeLsb = 26;
	localparam int RsMsb     = 24;
	localparam int RsLsb     = 20;
	localparam int RtMsb     = 19;
	localparam int RtLsb     = 15;
	localparam int RdMsb     = 14;
	localparam int RdLsb     = 10;
	localparam int ImmMsb    = 14;
	localparam int ImmLsb    = 0;

	typedef logic [WordWidth-1:0]    word_t;
	typedef logic [RegAddrWidth-1:0] regAddr_t;
	typedef logic [PcWidth-1:0]      pc_t;
	typedef logic [ImmWidth-1:0]     imm_t;
	typedef logic [OpcodeWidth-1:0]  opcode_t;
	typedef logic [NibbleWidth-1:0]  nibble_t;
	typedef nibble_t [NumDigits-1:0] dispNib_t; // low nibbles of r0..r3
	typedef logic [SegWidth-1:0]     seg_t;

	// opcode bits 5..4
	typedef enum logic [1:0] {
		classNop  = 2'd0,
		classAluR = 2'd1,
		classAluI = 2'd2,
		classLui  = 2'd3
	} opClass_e;

	// opcode bits 3..0, codes 8..15 give zero
	typedef enum logic [3:0] {
		aluAdd  = 4'd0,
		aluSub  = 4'd1,
		aluAnd  = 4'd2,
		aluOr   = 4'd3,
		aluXor  = 4'd4,
		aluNor  = 4'd5,
		aluSlt  = 4'd6,
		aluSltu = 4'd7
	} aluFunct_e;

	typedef struct packed {
		logic  valid;
		logic  done;
		word_t instr;
	} fetchOut_t;

	typedef struct packed {
		logic      writeEn;
		regAddr_t  dest;
		opClass_e  opClass;
		aluFunct_e funct;
		word_t     operandA;
		word_t     operandB;  // forwarded rt value
		imm_t      imm;
		logic      done;
	} exCtrl_t;

	typedef struct packed {
		logic     writeEn;
		regAddr_t dest;
		word_t    value;
		logic     done;
	} wbEntry_t;

endpackage

`default_nettype wire

// File: hw/fetchStage.sv
`timescale 1ns/1ns
`default_nettype none

module fetchStage (
	input  logic              clk,
	input  logic              rst,
	input  logic              progWe,
	input  cpuPkg::pc_t       progAddr,
	input  cpuPkg::word_t     progData,
	output cpuPkg::fetchOut_t fetchOut
);

	cpuPkg::word_t progMem [cpuPkg::ProgDepth];
	cpuPkg::pc_t   pc;
	cpuPkg::word_t instr;
	logic          endWord;
	logic          doneSticky;

	assign instr   = progMem[pc];   // async read at the current pc
	assign endWord = (instr == '0);

	// program load, accepted only while reset is held
	always_ff @(posedge clk) begin
		if (rst && progWe) begin
			progMem[progAddr] <= progData;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc         <= '0;
			doneSticky <= 1'b0;
		end else begin
			if (!endWord && !doneSticky) begin
				pc <= pc + cpuPkg::pc_t'(1);
			end
			doneSticky <= doneSticky | endWord; // sticks until reset
		end
	end

	// fetch/decode register
	always_ff @(posedge clk) begin
		if (rst) begin
			fetchOut <= '0;
		end else begin
			fetchOut.valid <= !endWord && !doneSticky;
			fetchOut.done  <= doneSticky;
			fetchOut.instr <= instr;
		end
	end

endmodule

`default_nettype wire

// File: hw/regFile.sv
`timescale 1ns/1ns
`default_nettype none

module regFile (
	input  logic             clk,
	input  logic             rst,
	input  logic             writeEn,
	input  cpuPkg::regAddr_t writeAddr,
	input  cpuPkg::word_t    writeData,
	input  cpuPkg::regAddr_t rsAddr,
	input  cpuPkg::regAddr_t rtAddr,
	output cpuPkg::word_t    rsValue,
	output cpuPkg::word_t    rtValue,
	output cpuPkg::dispNib_t dispNibbles
);

	cpuPkg::word_t regs [cpuPkg::NumRegs]; // r0 is writable like the others

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int r = 0; r < cpuPkg::NumRegs; r++) begin
				regs[r] <= '0;
			end
		end else if (writeEn) begin
			regs[writeAddr] <= writeData;
		end
	end

	assign rsValue = regs[rsAddr];
	assign rtValue = regs[rtAddr];

	for (genvar d = 0; d < cpuPkg::NumDigits; d++) begin : gDisp
		assign dispNibbles[d] = cpuPkg::nibble_t'(regs[d]);
	end

endmodule

`default_nettype wire

// File: hw/decodeStage.sv
`timescale 1ns/1ns
`default_nettype none

module decodeStage (
	input  logic              clk,
	input  logic              rst,
	input  cpuPkg::fetchOut_t fetchIn,
	input  cpuPkg::word_t     rsValue,
	input  cpuPkg::word_t     rtValue,
	input  cpuPkg::word_t     exResult,
	input  cpuPkg::wbEntry_t  wbEntry,
	output cpuPkg::regAddr_t  rsAddr,
	output cpuPkg::regAddr_t  rtAddr,
	output cpuPkg::exCtrl_t   exCtrl
);

	cpuPkg::word_t    instr;
	cpuPkg::opcode_t  opcode;
	cpuPkg::regAddr_t rdAddr;
	cpuPkg::opClass_e opClass;
	cpuPkg::exCtrl_t  exNext;

	// newest producer wins: execute, then writeback, then the file
	function automatic cpuPkg::word_t forwardOperand(
		input cpuPkg::regAddr_t addr,
		input cpuPkg::word_t    fileValue
	);
		cpuPkg::word_t value;
		if (exCtrl.writeEn && exCtrl.dest == addr) begin
			value = exResult;
		end else if (wbEntry.writeEn && wbEntry.dest == addr) begin
			value = wbEntry.value;
		end else begin
			value = fileValue;
		end
		return value;
	endfunction

	assign instr  = fetchIn.instr;
	assign opcode = instr[cpuPkg::OpcodeMsb:cpuPkg::OpcodeLsb];
	assign rsAddr = instr[cpuPkg::RsMsb:cpuPkg::RsLsb];
	assign rtAddr = instr[cpuPkg::RtMsb:cpuPkg::RtLsb];
	assign rdAddr = instr[cpuPkg::RdMsb:cpuPkg::RdLsb];

	assign opClass = cpuPkg::opClass_e'(opcode[5:4]);

	always_comb begin
		exNext          = '0;
		exNext.opClass  = opClass;
		exNext.funct    = cpuPkg::aluFunct_e'(opcode[3:0]);
		// nop words and bubbles never write
		exNext.writeEn  = fetchIn.valid && (opClass != cpuPkg::classNop);
		exNext.dest     = (opClass == cpuPkg::classAluR) ? rdAddr : rtAddr;
		exNext.operandA = forwardOperand(rsAddr, rsValue);
		exNext.operandB = forwardOperand(rtAddr, rtValue);
		exNext.imm      = instr[cpuPkg::ImmMsb:cpuPkg::ImmLsb];
		exNext.done     = fetchIn.done;
	end

	// decode/execute register
	always_ff @(posedge clk) begin
		if (rst) begin
			exCtrl <= '0;
		end else begin
			exCtrl <= exNext;
		end
	end

endmodule

`default_nettype wire

// File: hw/executeStage.sv
`timescale 1ns/1ns
`default_nettype none

module executeStage (
	input  logic             clk,
	input  logic             rst,
	input  cpuPkg::exCtrl_t  exCtrl,
	output cpuPkg::word_t    exResult,
	output cpuPkg::wbEntry_t wbEntry
);

	cpuPkg::word_t aluA;
	cpuPkg::word_t aluB;
	cpuPkg::word_t aluResult;
	cpuPkg::word_t luiValue;

	assign aluA = exCtrl.operandA;
	// immediate ops take the zero-extended constant
	assign aluB = (exCtrl.opClass == cpuPkg::classAluI) ?
		cpuPkg::word_t'(exCtrl.imm) : exCtrl.operandB;

	always_comb begin
		case (exCtrl.funct)
			cpuPkg::aluAdd:  aluResult = aluA + aluB;
			cpuPkg::aluSub:  aluResult = aluA - aluB;
			cpuPkg::aluAnd:  aluResult = aluA & aluB;
			cpuPkg::aluOr:   aluResult = aluA | aluB;
			cpuPkg::aluXor:  aluResult = aluA ^ aluB;
			cpuPkg::aluNor:  aluResult = ~(aluA | aluB);
			cpuPkg::aluSlt:  aluResult = cpuPkg::word_t'($signed(aluA) < $signed(aluB));
			cpuPkg::aluSltu: aluResult = cpuPkg::word_t'(aluA < aluB);
			default:         aluResult = '0; // unused function codes
		endcase
	end

	assign luiValue = cpuPkg::word_t'(exCtrl.imm) << cpuPkg::LuiShift;

	// load-upper or ALU result
	assign exResult = (exCtrl.opClass == cpuPkg::classLui) ? luiValue : aluResult;

	// execute/writeback register
	always_ff @(posedge clk) begin
		if (rst) begin
			wbEntry <= '0;
		end else begin
			wbEntry.writeEn <= exCtrl.writeEn;
			wbEntry.dest    <= exCtrl.dest;
			wbEntry.value   <= exResult;
			wbEntry.done    <= exCtrl.done;
		end
	end

endmodule

`default_nettype wire

// File: hw/hexDisplay.sv
`timescale 1ns/1ns
`default_nettype none

module hexDisplay (
	input  cpuPkg::dispNib_t dispNibbles,
	output cpuPkg::seg_t     hex0,
	output cpuPkg::seg_t     hex1,
	output cpuPkg::seg_t     hex2,
	output cpuPkg::seg_t     hex3
);

	// active low, bit 0 = top segment up to bit 6 = middle
	function automatic cpuPkg::seg_t glyph(input cpuPkg::nibble_t nib);
		cpuPkg::seg_t seg;
		case (nib)
			4'h0: seg = 7'b1000000;
			4'h1: seg = 7'b1111001;
			4'h2: seg = 7'b0100100;
			4'h3: seg = 7'b0110000;
			4'h4: seg = 7'b0011001;
			4'h5: seg = 7'b0010010;
			4'h6: seg = 7'b0000010;
			4'h7: seg = 7'b1111000;
			4'h8: seg = 7'b0000000;
			4'h9: seg = 7'b0010000;
			4'hA: seg = 7'b0001000;
			4'hB: seg = 7'b0000011; // lowercase b
			4'hC: seg = 7'b1000110;
			4'hD: seg = 7'b0100001; // lowercase d
			4'hE: seg = 7'b0000110;
			4'hF: seg = 7'b0001110;
		endcase
		return seg;
	endfunction

	assign hex0 = glyph(dispNibbles[0]);
	assign hex1 = glyph(dispNibbles[1]);
	assign hex2 = glyph(dispNibbles[2]);
	assign hex3 = glyph(dispNibbles[3]);

endmodule

`default_nettype wire

// File: hw/cpuTop.sv
`timescale 1ns/1ns
`default_nettype none

module cpuTop (
	input  logic          clk,
	input  logic          rst,
	input  logic          progWe,
	input  cpuPkg::pc_t   progAddr,
	input  cpuPkg::word_t progData,
	output logic          done,
	output cpuPkg::seg_t  hex0,
	output cpuPkg::seg_t  hex1,
	output cpuPkg::seg_t  hex2,
	output cpuPkg::seg_t  hex3
);

	cpuPkg::fetchOut_t fetchOut;
	cpuPkg::exCtrl_t   exCtrl;
	cpuPkg::wbEntry_t  wbEntry;
	cpuPkg::word_t     exResult;
	cpuPkg::regAddr_t  rsAddr;
	cpuPkg::regAddr_t  rtAddr;
	cpuPkg::word_t     rsValue;
	cpuPkg::word_t     rtValue;
	cpuPkg::dispNib_t  dispNibbles;

	fetchStage uFetch (
		.clk      (clk),
		.rst      (rst),
		.progWe   (progWe),
		.progAddr (progAddr),
		.progData (progData),
		.fetchOut (fetchOut)
	);

	decodeStage uDecode (
		.clk      (clk),
		.rst      (rst),
		.fetchIn  (fetchOut),
		.rsValue  (rsValue),
		.rtValue  (rtValue),
		.exResult (exResult),
		.wbEntry  (wbEntry),   // writeback forwarding
		.rsAddr   (rsAddr),
		.rtAddr   (rtAddr),
		.exCtrl   (exCtrl)
	);

	regFile uRegFile (
		.clk         (clk),
		.rst         (rst),
		.writeEn     (wbEntry.writeEn),
		.writeAddr   (wbEntry.dest),
		.writeData   (wbEntry.value),
		.rsAddr      (rsAddr),
		.rtAddr      (rtAddr),
		.rsValue     (rsValue),
		.rtValue     (rtValue),
		.dispNibbles (dispNibbles)
	);

	executeStage uExecute (
		.clk      (clk),
		.rst      (rst),
		.exCtrl   (exCtrl),
		.exResult (exResult),
		.wbEntry  (wbEntry)
	);

	hexDisplay uHex (
		.dispNibbles (dispNibbles),
		.hex0        (hex0),
		.hex1        (hex1),
		.hex2        (hex2),
		.hex3        (hex3)
	);

	assign done = wbEntry.done; // end mark after the last write

endmodule

`default_nettype wire

// File: dv/cpuChecker.sv
`timescale 1ns/1ns
`default_nettype none

module cpuChecker (
	input logic         clk,
	input logic         rst,
	input logic         done,
	input cpuPkg::seg_t hex0,
	input cpuPkg::seg_t hex1,
	input cpuPkg::seg_t hex2,
	input cpuPkg::seg_t hex3
);

	localparam int TimeoutCycles = 500;
	localparam int HoldCycles    = 20;
	localparam logic [4*cpuPkg::SegWidth-1:0] AllZeroGlyphs = {4{7'b1000000}};

	int passCount = 0;
	int failCount = 0;

	// digits packed as {hex3, hex2, hex1, hex0}
	function automatic logic [4*cpuPkg::SegWidth-1:0] glyphsNow();
		return {hex3, hex2, hex1, hex0};
	endfunction

	task automatic checkRun(
		input string                           name,
		input int                              endIdx,
		input logic [4*cpuPkg::SegWidth-1:0] expGlyphs
	);
		int n;
		int errs;
		logic [4*cpuPkg::SegWidth-1:0] seen;
		errs = 0;
		@(negedge clk); // first cycle out of reset
		if (rst !== 1'b0) begin
			$display("%s: reset was still asserted when the run started", name);
			errs++;
		end
		if (done !== 1'b0) begin
			$display("FAILED %0t: %s done high right after reset", $time, name);
			errs++;
		end
		if (glyphsNow() !== AllZeroGlyphs) begin
			$display("FAILED %0t: %s digits %h not zero after reset", $time, name, glyphsNow());
			errs++;
		end
		n = 0; // cycle index, the pc addresses word n here
		while (done !== 1'b1 && n < TimeoutCycles) begin
			@(negedge clk);
			n++;
		end
		if (done !== 1'b1) begin
			$display("%s: timed out after %0d cycles waiting for done", name, n);
			errs++;
		end else begin
			if (n != endIdx + 4) begin
				$display("FAILED %0t: %s done after %0d cycles, expected %0d",
					$time, name, n, endIdx + 4);
				errs++;
			end
			seen = glyphsNow();
			for (int d = 0; d < 4; d++) begin
				if (seen[d*7 +: 7] !== expGlyphs[d*7 +: 7]) begin
					$display("FAILED %0t: %s hex%0d is %b, expected %b", $time, name, d,
						seen[d*7 +: 7], expGlyphs[d*7 +: 7]);
					errs++;
				end
			end
			// nothing may change once done is up
			for (int c = 0; c < HoldCycles; c++) begin
				@(negedge clk);
				if (done !== 1'b1 || glyphsNow() !== seen) begin
					$display("FAILED %0t: %s outputs changed after done", $time, name);
					errs++;
					break;
				end
			end
		end
		if (errs == 0) begin
			passCount++;
			$display("test %s: passed", name);
		end else begin
			failCount++;
			$display("test %s: failed with %0d errors", name, errs);
		end
	endtask

	task automatic printSummary();
		$display("tests run %0d, passed %0d, failed %0d",
			passCount + failCount, passCount, failCount);
	endtask

endmodule

`default_nettype wire

// File: dv/cpuTop_assert.sv
`timescale 1ns/1ns
`default_nettype none

module cpuTopAssert (
	input logic         clk,
	input logic         rst,
	input logic         done,
	input cpuPkg::seg_t hex0,
	input cpuPkg::seg_t hex1,
	input cpuPkg::seg_t hex2,
	input cpuPkg::seg_t hex3
);

	localparam cpuPkg::seg_t ZeroGlyph = 7'b1000000;

	doneSticky: assert property (@(posedge clk) disable iff (rst) !$fell(done))
		else $error("done fell while out of reset");

	doneLowAfterReset: assert property (@(posedge clk) $fell(rst) |-> !done)
		else $error("done high in the first cycle after reset");

	digitsZeroAfterReset: assert property (@(posedge clk) $fell(rst) |->
		(hex0 == ZeroGlyph && hex1 == ZeroGlyph && hex2 == ZeroGlyph && hex3 == ZeroGlyph))
		else $error("digits not zero after reset");

endmodule

bind cpuTop cpuTopAssert uAssert (.clk(clk), .rst(rst), .done(done),
	.hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3));

`default_nettype wire

// File: dv/cpuTb.sv
`timescale 1ns/1ns
`default_nettype none

module cpuTb;

	logic          clk;
	logic          rst;
	logic          progWe;
	cpuPkg::pc_t   progAddr;
	cpuPkg::word_t progData;
	logic          done;
	cpuPkg::seg_t  hex0;
	cpuPkg::seg_t  hex1;
	cpuPkg::seg_t  hex2;
	cpuPkg::seg_t  hex3;

	cpuPkg::word_t prog [cpuPkg::ProgDepth];
	cpuPkg::word_t model [cpuPkg::NumRegs];
	int            endIdx;

	initial clk = 1'b0;
	always #10 clk = ~clk;

	cpuTop uut (
		.clk      (clk),
		.rst      (rst),
		.progWe   (progWe),
		.progAddr (progAddr),
		.progData (progData),
		.done     (done),
		.hex0     (hex0),
		.hex1     (hex1),
		.hex2     (hex2),
		.hex3     (hex3)
	);

	cpuChecker uChecker (.clk(clk), .rst(rst), .done(done),
		.hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3));

	// segments top, upper-right, lower-right, bottom, lower-left, upper-left, middle
	function automatic cpuPkg::seg_t nibToGlyph(input logic [3:0] n);
		logic [15:0][6:0] table_;
		table_ = {7'b0001110, 7'b0000110, 7'b0100001, 7'b1000110,
			7'b0000011, 7'b0001000, 7'b0010000, 7'b0000000,
			7'b1111000, 7'b0000010, 7'b0010010, 7'b0011001,
			7'b0110000, 7'b0100100, 7'b1111001, 7'b1000000};
		return table_[n];
	endfunction

	function automatic cpuPkg::word_t aluModel(input logic [3:0] f,
		input cpuPkg::word_t a, input cpuPkg::word_t b);
		case (f)
			4'd0: return a + b;
			4'd1: return a - b;
			4'd2: return a & b;
			4'd3: return a | b;
			4'd4: return a ^ b;
			4'd5: return ~(a | b);
			4'd6: return {31'd0, $signed(a) < $signed(b)};
			4'd7: return {31'd0, a < b};
			default: return '0; // codes 8..15
		endcase
	endfunction

	task automatic stepModel(input cpuPkg::word_t ins);
		logic [1:0]       cls;
		logic [3:0]       f;
		cpuPkg::regAddr_t rs;
		cpuPkg::regAddr_t rt;
		cpuPkg::regAddr_t rd;
		cpuPkg::word_t    imm;
		cls = ins[31:30];
		f   = ins[29:26];
		rs  = ins[24:20];
		rt  = ins[19:15];
		rd  = ins[14:10];
		imm = {17'd0, ins[14:0]};
		case (cls)
			2'd1: model[rd] = aluModel(f, model[rs], model[rt]);
			2'd2: model[rt] = aluModel(f, model[rs], imm);
			2'd3: model[rt] = imm << 17;
			default: ; // nop word
		endcase
	endtask

	function automatic cpuPkg::regAddr_t randReg();
		return cpuPkg::regAddr_t'($urandom_range(0, 7));
	endfunction

	function automatic cpuPkg::word_t encode(input logic [1:0] cls, input logic [3:0] f,
		input cpuPkg::regAddr_t rs, input cpuPkg::regAddr_t rt, input logic [14:0] low);
		return {cls, f, 1'b0, rs, rt, low};
	endfunction

	// kind 0 R-type, 1 forwarding chains, 2 immediate mix, 3 nops mixed in
	task automatic genProgram(input int kind);
		cpuPkg::regAddr_t dests [cpuPkg::ProgDepth];
		cpuPkg::regAddr_t rs;
		cpuPkg::regAddr_t rt;
		cpuPkg::regAddr_t rd;
		int               k;
		int               cls;
		for (int a = 0; a < cpuPkg::ProgDepth; a++) begin
			prog[a] = {6'b010101, 1'b0, 5'd1, 5'd2, 5'd3, 4'd0, 6'(a)}; // nor into r3
		end
		endIdx = int'($urandom_range(8, 30));
		for (int i = 0; i < endIdx; i++) begin
			rs  = randReg();
			rt  = randReg();
			rd  = randReg();
			cls = (kind >= 2) ? int'($urandom_range(1, 3)) : 1;
			if (kind == 1) begin
				k = int'($urandom_range(1, 3));
				if (i >= k) rs = dests[i-k];
				if (i >= 1) rt = dests[i-1];
			end
			if (kind == 3 && $urandom_range(0, 2) == 0) begin
				prog[i] = {2'b00, 4'($urandom_range(1, 15)), 26'($urandom)};
			end else if (cls == 1) begin
				prog[i] = encode(2'd1, 4'($urandom_range(0, 7)), rs, rt, {rd, 10'($urandom)});
			end else begin
				prog[i] = encode(2'(cls), 4'($urandom_range(0, 15)), rs, rt, 15'($urandom));
			end
			dests[i] = (cls == 1) ? rd : rt;
		end
		prog[endIdx]   = '0;
		prog[endIdx+1] = encode(2'd1, 4'd4, 5'd1, 5'd2, {5'd0, 10'd0}); // must never run
	endtask

	task automatic loadAndRun(input string name, input int kind);
		logic [4*cpuPkg::SegWidth-1:0] expGlyphs;
		genProgram(kind);
		for (int r = 0; r < cpuPkg::NumRegs; r++) begin
			model[r] = '0;
		end
		for (int i = 0; i < endIdx; i++) begin
			stepModel(prog[i]);
		end
		for (int d = 0; d < 4; d++) begin
			expGlyphs[d*7 +: 7] = nibToGlyph(model[d][3:0]);
		end
		@(posedge clk);
		rst <= 1'b1;
		for (int a = 0; a < cpuPkg::ProgDepth; a++) begin
			@(posedge clk);
			progWe   <= 1'b1;
			progAddr <= cpuPkg::pc_t'(a);
			progData <= prog[a];
		end
		@(posedge clk);
		progWe <= 1'b0;
		@(posedge clk);
		rst <= 1'b0;
		uChecker.checkRun(name, endIdx, expGlyphs);
	endtask

	initial begin
		void'($urandom(12100));
		rst      = 1'b1;
		progWe   = 1'b0;
		progAddr = '0;
		progData = '0;
		repeat (8) @(posedge clk);
		loadAndRun("rtype", 0);
		loadAndRun("forwarding", 1);
		loadAndRun("immediate", 2);
		loadAndRun("endword", 3);
		for (int r = 0; r < 10; r++) begin
			loadAndRun($sformatf("repeat%0d", r), r % 4);
		end
		uChecker.printSummary();
		if (uChecker.failCount == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
hw/cpuPkg.sv
hw/fetchStage.sv
hw/regFile.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/hexDisplay.sv
hw/cpuTop.sv
dv/cpuChecker.sv
dv/cpuTop_assert.sv
dv/cpuTb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = cpuTb
FILELIST  = sim.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
